//--- src/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     dataT;
    typedef logic [REG_ADDR_W-1:0] regIdxT;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;  // R-type, funct picks the op
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct field under SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } aluOpT;

    // one fetched instruction with its address
    typedef struct packed {
        dataT pc;
        dataT instr;
    } queueEntryT;

    typedef struct packed {
        logic   valid;
        dataT   pc;
        aluOpT  aluOp;
        dataT   srcA;
        dataT   srcB;      // immediate already selected
        logic   regWrite;
        regIdxT writeReg;
    } issueSlotT;

    typedef struct packed {
        logic   regWrite;
        regIdxT writeReg;
        dataT   data;
        dataT   pc;
    } wbT;

endpackage

`default_nettype wire

//--- src/fetchIf.sv
`timescale 1ns/1ns
`default_nettype none

// pairs of fetched instructions going into the queue
interface fetchIf
    import mipsPkg::*;
#(
    parameter int CNT_W = 4
) ();

    logic             pushValid;
    queueEntryT       pushLo;     // lower address
    queueEntryT       pushHi;
    logic [CNT_W-1:0] freeSlots;  // empty queue entries

    modport fetch (output pushValid, pushLo, pushHi, input freeSlots);
    modport queue (input pushValid, pushLo, pushHi, output freeSlots);

endinterface

`default_nettype wire

//--- src/issueIf.sv
`timescale 1ns/1ns
`default_nettype none

// two oldest queue entries offered to issue, pop count returned
interface issueIf
    import mipsPkg::*;
();

    logic       headValid;
    queueEntryT head;       // oldest
    logic       nextValid;
    queueEntryT next;
    logic [1:0] popCount;   // 0, 1 or 2

    modport queue (
        output headValid, head, nextValid, next,
        input  popCount
    );

    modport issue (
        input  headValid, head, nextValid, next,
        output popCount
    );

endinterface

`default_nettype wire

//--- src/instrFetch.sv
`timescale 1ns/1ns
`default_nettype none

module instrFetch
    import mipsPkg::*;
#(
    parameter dataT RESET_PC = 32'hBFC0_0000
) (
    input  logic  clk,
    input  logic  rstN_i,
    output dataT  pc_o,
    output logic  instEn_o,
    input  dataT  inst1_i,
    input  dataT  inst2_i,
    input  logic  iCacheStall_i,
    fetchIf.fetch fq
);

    dataT pcReg;        // next pair to request
    dataT pendPc;       // address of the pair in flight
    logic pendValid;
    logic fetchOn;      // set once reset is released
    logic completing;

    // the pair in flight returns in the first cycle without a stall
    assign completing = pendValid && !iCacheStall_i;

    // room is needed for the pair in flight and for the new one
    assign instEn_o = fetchOn && (!pendValid || completing) && (fq.freeSlots >= 4);
    assign pc_o     = pcReg;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcReg     <= RESET_PC;
            pendValid <= 1'b0;
            fetchOn   <= 1'b0;
        end else begin
            fetchOn <= 1'b1;
            if (instEn_o) begin
                pcReg     <= pcReg + 32'd8;
                pendValid <= 1'b1;
            end else if (completing) begin
                pendValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instEn_o) begin
            pendPc <= pcReg;
        end
    end

    // each word goes into the queue with its own address
    assign fq.pushValid = completing;
    assign fq.pushLo    = '{pc: pendPc, instr: inst1_i};
    assign fq.pushHi    = '{pc: pendPc + 32'd4, instr: inst2_i};

endmodule

`default_nettype wire

//--- src/instrQueue.sv
`timescale 1ns/1ns
`default_nettype none

module instrQueue
    import mipsPkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic  clk,
    input  logic  rstN_i,
    fetchIf.queue fq,
    issueIf.queue iq
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    queueEntryT       mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] pushCnt;

    assign pushCnt = fq.pushValid ? CNT_W'(2) : '0;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (fq.pushValid) begin
                wrPtr <= wrPtr + PTR_W'(2);
            end
            rdPtr <= rdPtr + PTR_W'(iq.popCount);
            count <= count + pushCnt - CNT_W'(iq.popCount);
        end
    end

    // both words of a pair land in one cycle, lower address first
    always_ff @(posedge clk) begin
        if (fq.pushValid) begin
            mem[wrPtr]               <= fq.pushLo;
            mem[wrPtr + PTR_W'(1)]   <= fq.pushHi;
        end
    end

    assign fq.freeSlots = CNT_W'(QUEUE_DEPTH) - count;

    assign iq.headValid = (count >= CNT_W'(1));
    assign iq.nextValid = (count >= CNT_W'(2));
    assign iq.head      = mem[rdPtr];
    assign iq.next      = mem[rdPtr + PTR_W'(1)];

endmodule

`default_nettype wire

//--- src/issueStage.sv
`timescale 1ns/1ns
`default_nettype none

module issueStage
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      rstN_i,
    issueIf.issue     iq,
    output regIdxT    rdAddr_o [4],
    input  dataT      rdData_i [4],
    input  wbT        exFwd_i [2],
    input  wbT        wb_i [2],
    output issueSlotT master_o,
    output issueSlotT slave_o
);

    typedef struct packed {
        logic   supported;
        aluOpT  aluOp;
        logic   useImm;
        dataT   imm;
        logic   regWrite;
        regIdxT writeReg;
    } decT;

    decT       headDec;
    decT       nextDec;
    logic      pairDep;
    logic      masterGo;
    logic      slaveGo;
    dataT      masterRt;
    dataT      slaveRt;
    issueSlotT masterNext;
    issueSlotT slaveNext;

    function automatic decT decode(input dataT instr);
        decT d;
        d.supported = 1'b1;
        d.aluOp     = ALU_ADD;
        d.useImm    = (instr[31:26] != OP_SPECIAL);
        d.imm       = {{16{instr[15]}}, instr[15:0]};
        d.writeReg  = d.useImm ? instr[20:16] : instr[15:11];  // rt for I-type, rd for R-type
        case (instr[31:26])
            OP_SPECIAL: begin
                case (instr[5:0])
                    FN_ADDU: d.aluOp = ALU_ADD;
                    FN_SUBU: d.aluOp = ALU_SUB;
                    FN_AND:  d.aluOp = ALU_AND;
                    FN_OR:   d.aluOp = ALU_OR;
                    FN_XOR:  d.aluOp = ALU_XOR;
                    FN_SLT:  d.aluOp = ALU_SLT;
                    FN_SLTU: d.aluOp = ALU_SLTU;
                    default: d.supported = 1'b0;
                endcase
            end
            OP_ADDIU: d.aluOp = ALU_ADD;
            OP_SLTI:  d.aluOp = ALU_SLT;
            OP_ANDI:  d.aluOp = ALU_AND;
            OP_ORI:   d.aluOp = ALU_OR;
            OP_XORI:  d.aluOp = ALU_XOR;
            OP_LUI:   d.aluOp = ALU_LUI;
            default:  d.supported = 1'b0;
        endcase
        // logical immediates are zero extended
        if (instr[31:26] inside {OP_ANDI, OP_ORI, OP_XORI}) begin
            d.imm = {16'b0, instr[15:0]};
        end
        d.regWrite = d.supported && (d.writeReg != '0);
        return d;
    endfunction

    // younger results override older ones, W before E, master before slave
    function automatic dataT forward(input regIdxT r, input dataT rfData);
        dataT v;
        v = rfData;
        for (int i = 0; i < 2; i++) begin
            if (wb_i[i].regWrite && (wb_i[i].writeReg == r)) begin
                v = wb_i[i].data;
            end
        end
        for (int i = 0; i < 2; i++) begin
            if (exFwd_i[i].regWrite && (exFwd_i[i].writeReg == r)) begin
                v = exFwd_i[i].data;
            end
        end
        return v;
    endfunction

    assign rdAddr_o[0] = iq.head.instr[25:21];
    assign rdAddr_o[1] = iq.head.instr[20:16];
    assign rdAddr_o[2] = iq.next.instr[25:21];
    assign rdAddr_o[3] = iq.next.instr[20:16];

    assign headDec = decode(iq.head.instr);
    assign nextDec = decode(iq.next.instr);

    // slave reading the master's destination waits for the next cycle
    assign pairDep = headDec.regWrite &&
                     ((iq.next.instr[25:21] == headDec.writeReg) ||
                      (!nextDec.useImm && (iq.next.instr[20:16] == headDec.writeReg)));

    assign masterGo    = iq.headValid;
    assign slaveGo     = iq.nextValid && nextDec.supported && !pairDep;
    assign iq.popCount = {1'b0, masterGo} + {1'b0, slaveGo};

    always_comb begin
        masterRt = forward(iq.head.instr[20:16], rdData_i[1]);
        slaveRt  = forward(iq.next.instr[20:16], rdData_i[3]);

        masterNext.valid    = 1'b1;
        masterNext.pc       = iq.head.pc;
        masterNext.aluOp    = headDec.aluOp;
        masterNext.srcA     = forward(iq.head.instr[25:21], rdData_i[0]);
        masterNext.srcB     = headDec.useImm ? headDec.imm : masterRt;
        masterNext.regWrite = headDec.regWrite;
        masterNext.writeReg = headDec.writeReg;

        slaveNext.valid     = 1'b1;
        slaveNext.pc        = iq.next.pc;
        slaveNext.aluOp     = nextDec.aluOp;
        slaveNext.srcA      = forward(iq.next.instr[25:21], rdData_i[2]);
        slaveNext.srcB      = nextDec.useImm ? nextDec.imm : slaveRt;
        slaveNext.regWrite  = nextDec.regWrite;
        slaveNext.writeReg  = nextDec.writeReg;
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            master_o <= '0;
            slave_o  <= '0;
        end else begin
            master_o <= masterGo ? masterNext : '0;  // bubble when queue is empty
            slave_o  <= slaveGo ? slaveNext : '0;
        end
    end

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile
    import mipsPkg::*;
(
    input  logic   clk,
    input  logic   rstN_i,
    input  regIdxT rdAddr_i [4],
    output dataT   rdData_o [4],
    input  wbT     wb_i [2]
);

    dataT regs [32];

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rdData_o[k] = regs[rdAddr_i[k]];
        end
    end

    // slave write comes last, the younger instruction wins
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (wb_i[i].regWrite) begin
                    regs[wb_i[i].writeReg] <= wb_i[i].data;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/execStage.sv
`timescale 1ns/1ns
`default_nettype none

module execStage
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      rstN_i,
    input  issueSlotT master_i,
    input  issueSlotT slave_i,
    output wbT        exFwd_o [2],
    output wbT        wb_o [2]
);

    issueSlotT lane [2];

    function automatic dataT alu(input aluOpT op, input dataT a, input dataT b);
        dataT r;
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLT:  r = dataT'($signed(a) < $signed(b));
            ALU_SLTU: r = dataT'(a < b);
            ALU_LUI:  r = {b[15:0], 16'b0};
            default:  r = '0;
        endcase
        return r;
    endfunction

    assign lane[0] = master_i;
    assign lane[1] = slave_i;

    // E results, also forwarded back to issue
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            exFwd_o[i].regWrite = lane[i].valid && lane[i].regWrite;
            exFwd_o[i].writeReg = lane[i].writeReg;
            exFwd_o[i].data     = alu(lane[i].aluOp, lane[i].srcA, lane[i].srcB);
            exFwd_o[i].pc       = lane[i].pc;
        end
    end

    // W stage
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            wb_o <= '{default: '0};
        end else begin
            wb_o <= exFwd_o;
        end
    end

endmodule

`default_nettype wire

//--- src/dualIssueCore.sv
`timescale 1ns/1ns
`default_nettype none

module dualIssueCore
    import mipsPkg::*;
#(
    parameter dataT RESET_PC    = 32'hBFC0_0000,
    parameter int   QUEUE_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rstN_i,
    output dataT       pc_o,
    output logic       instEn_o,
    input  dataT       inst1_i,
    input  dataT       inst2_i,
    input  logic       iCacheStall_i,
    output dataT       dbgMasterPc_o,
    output logic [3:0] dbgMasterWen_o,
    output regIdxT     dbgMasterWnum_o,
    output dataT       dbgMasterWdata_o,
    output dataT       dbgSlavePc_o,
    output logic [3:0] dbgSlaveWen_o,
    output regIdxT     dbgSlaveWnum_o,
    output dataT       dbgSlaveWdata_o
);

    issueSlotT masterSlot;
    issueSlotT slaveSlot;
    regIdxT    rdAddr [4];
    dataT      rdData [4];
    wbT        exFwd [2];
    wbT        wb [2];      // index 0 master, 1 slave

    fetchIf #(.CNT_W($clog2(QUEUE_DEPTH) + 1)) fetchBus ();
    issueIf issueBus ();

    instrFetch #(.RESET_PC(RESET_PC)) fetchU (
        .clk, .rstN_i, .pc_o, .instEn_o, .inst1_i, .inst2_i, .iCacheStall_i,
        .fq(fetchBus.fetch)
    );

    instrQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queueU (
        .clk, .rstN_i, .fq(fetchBus.queue), .iq(issueBus.queue)
    );

    issueStage issueU (
        .clk, .rstN_i, .iq(issueBus.issue), .rdAddr_o(rdAddr), .rdData_i(rdData),
        .exFwd_i(exFwd), .wb_i(wb), .master_o(masterSlot), .slave_o(slaveSlot)
    );

    regFile rfU (.clk, .rstN_i, .rdAddr_i(rdAddr), .rdData_o(rdData), .wb_i(wb));

    execStage execU (
        .clk, .rstN_i, .master_i(masterSlot), .slave_i(slaveSlot),
        .exFwd_o(exFwd), .wb_o(wb)
    );

    // debug ports, byte enables all follow regWrite
    assign dbgMasterPc_o    = wb[0].pc;
    assign dbgMasterWen_o   = {4{wb[0].regWrite}};
    assign dbgMasterWnum_o  = wb[0].writeReg;
    assign dbgMasterWdata_o = wb[0].data;
    assign dbgSlavePc_o     = wb[1].pc;
    assign dbgSlaveWen_o    = {4{wb[1].regWrite}};
    assign dbgSlaveWnum_o   = wb[1].writeReg;
    assign dbgSlaveWdata_o  = wb[1].data;

endmodule

`default_nettype wire

//--- tests/tbDualIssue.sv
`timescale 1ns/1ns
`default_nettype none

module tbDualIssue
    import mipsPkg::*;
();

    localparam dataT RESET_PC  = 32'hBFC0_0000;
    localparam int   PROG_LEN  = 256;
    localparam int   RUN_LIMIT = 5000;  // cycles
    // tables indexed by a 3-bit draw, some entries repeat
    localparam logic [47:0] FN_LIST = {FN_ADDU, FN_SUBU, FN_AND, FN_OR,
                                       FN_XOR, FN_SLT, FN_SLTU, FN_XOR};
    localparam logic [47:0] OP_LIST = {OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI,
                                       OP_XORI, OP_LUI, OP_ADDIU, OP_ORI};

    logic       clk, rstN_i, instEn_o, iCacheStall_i;
    dataT       pc_o, inst1_i, inst2_i;
    dataT       dbgMasterPc_o, dbgMasterWdata_o, dbgSlavePc_o, dbgSlaveWdata_o;
    logic [3:0] dbgMasterWen_o, dbgSlaveWen_o;
    regIdxT     dbgMasterWnum_o, dbgSlaveWnum_o;

    dataT        rom [PROG_LEN];
    dataT        refRegs [32];
    dataT        expPc [$];
    dataT        expVal [$];
    regIdxT      expReg [$];
    logic [15:0] lfsr;
    logic        pend, completing;
    dataT        nextReqPc, pendPc;
    int          stallLeft, errors, checks, retired, requests, stalls, mark;

    dualIssueCore dut (.*);

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic dataT genInstr();
        logic [3:0] kind;
        logic [2:0] sel;
        dataT       w;
        kind = 4'(randBits(4));
        sel  = 3'(randBits(3));
        if (kind == 4'd0) begin
            w = '0;                               // nop
        end else if (kind == 4'd1) begin
            w = {6'h3f, 26'(randBits(26))};       // opcode outside the set
        end else if (kind < 4'd9) begin
            w = {OP_SPECIAL, 2'b0, 3'(randBits(3)), 2'b0, 3'(randBits(3)),
                 2'b0, 3'(randBits(3)), 5'b0, FN_LIST[sel*6 +: 6]};
        end else begin
            w = {OP_LIST[sel*6 +: 6], 2'b0, 3'(randBits(3)), 2'b0, 3'(randBits(3)),
                 16'(randBits(16))};
        end
        return w;
    endfunction

    function automatic dataT romWord(input dataT addr);
        dataT idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < PROG_LEN) ? rom[idx[7:0]] : 32'h0;  // nop past the program
    endfunction

    // sequential execution, one expected write per retiring instruction
    task automatic runModel();
        dataT   w, a, b, sx, zx, res;
        regIdxT dst;
        logic   ok;
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w   = rom[i];
            a   = refRegs[w[25:21]];
            b   = refRegs[w[20:16]];
            sx  = {{16{w[15]}}, w[15:0]};
            zx  = {16'b0, w[15:0]};
            dst = (w[31:26] == OP_SPECIAL) ? w[15:11] : w[20:16];
            ok  = 1'b1;
            res = '0;
            case (w[31:26])
                OP_SPECIAL: begin
                    case (w[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                        FN_SLTU: res = {31'b0, a < b};
                        default: ok = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + sx;
                OP_SLTI:  res = {31'b0, $signed(a) < $signed(sx)};
                OP_ANDI:  res = a & zx;
                OP_ORI:   res = a | zx;
                OP_XORI:  res = a ^ zx;
                OP_LUI:   res = {w[15:0], 16'b0};
                default:  ok = 1'b0;
            endcase
            if (ok && (dst != 5'd0)) begin
                refRegs[dst] = res;
                expPc.push_back(RESET_PC + 32'(4 * i));
                expReg.push_back(dst);
                expVal.push_back(res);
            end
        end
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkRetire(input string lane, input logic [3:0] wen, input dataT pc,
                               input regIdxT wnum, input dataT wdata);
        if (wen != 4'h0) begin
            checkVal({lane, "Wen_o"}, wen, 32'hf);
            if (retired >= expPc.size()) begin
                $display("%0t: %s reported a write after the last expected one", $time, lane);
                errors++;
            end else begin
                checkVal({lane, "Pc_o"}, pc, expPc[retired]);
                checkVal({lane, "Wnum_o"}, wnum, expReg[retired]);
                checkVal({lane, "Wdata_o"}, wdata, expVal[retired]);
            end
            retired++;
        end
    endtask

    // drive just after the edge, sample at the falling edge
    task automatic runCycle(input logic rstLevel);
        @(posedge clk);
        #1;
        rstN_i        = rstLevel;
        iCacheStall_i = pend && (stallLeft > 0);
        completing    = pend && (stallLeft == 0);
        inst1_i       = completing ? romWord(pendPc) : '0;
        inst2_i       = completing ? romWord(pendPc + 32'd4) : '0;
        if (iCacheStall_i) begin
            stallLeft--;
            stalls++;
        end
        @(negedge clk);
        if (iCacheStall_i) begin
            checkVal("instEn_o", instEn_o, 0);  // request waits, port holds
            checkVal("pc_o", pc_o, nextReqPc);
        end
        if (completing) begin
            pend = 1'b0;
        end
        if (instEn_o) begin
            if (pend) begin
                $display("%0t: new request while the previous one is still waiting", $time);
                errors++;
            end
            checkVal("pc_o", pc_o, nextReqPc);
            pend      = 1'b1;
            pendPc    = nextReqPc;
            stallLeft = int'(randBits(2));  // 0 to 3 stall cycles
            nextReqPc = nextReqPc + 32'd8;
            requests++;
        end
        checkRetire("dbgMaster", dbgMasterWen_o, dbgMasterPc_o, dbgMasterWnum_o, dbgMasterWdata_o);
        checkRetire("dbgSlave", dbgSlaveWen_o, dbgSlavePc_o, dbgSlaveWnum_o, dbgSlaveWdata_o);
    endtask

    initial begin
        clk           = 1'b0;
        rstN_i        = 1'b0;
        iCacheStall_i = 1'b0;
        inst1_i       = '0;
        inst2_i       = '0;
        pend          = 1'b0;
        completing    = 1'b0;
        pendPc        = '0;
        nextReqPc     = RESET_PC;
        stallLeft     = 0;
        errors        = 0;
        checks        = 0;
        retired       = 0;
        requests      = 0;
        stalls        = 0;
        lfsr          = 16'd52532;
        for (int i = 0; i < PROG_LEN; i++) begin
            rom[i] = genInstr();
        end
        runModel();

        mark = errors;
        for (int c = 0; c < 4; c++) begin
            runCycle(1'b0);
            checkVal("instEn_o", instEn_o, 0);
            checkVal("dbgMasterWen_o", dbgMasterWen_o, 0);
            checkVal("dbgSlaveWen_o", dbgSlaveWen_o, 0);
        end
        $display("reset test done, %0d errors", errors - mark);

        mark = errors;
        for (int c = 0; (c < RUN_LIMIT) && (retired < expPc.size()); c++) begin
            runCycle(1'b1);
        end
        if (retired < expPc.size()) begin
            $display("timeout: only %0d of %0d expected writes retired", retired, expPc.size());
            errors++;
        end
        $display("program test done, %0d writes, %0d errors", retired, errors - mark);

        // nops only from here on, any write is a duplicate
        mark = errors;
        for (int c = 0; c < 40; c++) begin
            runCycle(1'b1);
        end
        $display("drain test done, %0d errors", errors - mark);

        $display("checks %0d, errors %0d, requests %0d, stall cycles %0d",
                 checks, errors, requests, stalls);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/mipsPkg.sv
src/fetchIf.sv
src/issueIf.sv
src/instrFetch.sv
src/instrQueue.sv
src/issueStage.sv
src/regFile.sv
src/execStage.sv
src/dualIssueCore.sv
tests/tbDualIssue.sv
